/* iq_core.f */
logic/uop_pkg.sv
logic/iq_pkg.sv
logic/dispatch_stage.sv
logic/issue_queue.sv
logic/issue_alu.sv
logic/iq_core.sv
test/tb_iq_core.sv

/* Makefile */
SIM  := obj_dir/Vtb_iq_core
SRCS := $(shell cat iq_core.f)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes.
$(SIM): iq_core.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_iq_core -f iq_core.f -o Vtb_iq_core

# The testbench reads its vectors relative to the project root.
run: $(SIM) test/iq_core_vectors.txt
	./$(SIM) > sim.log
	cat sim.log
	@if grep -q "tests failed" sim.log; then \
		echo "Simulation reported failures, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* test/iq_core_vectors.txt */
# stall mask  op a b  op a b  op a b  op a b   (all fields hex, one group per line)
# stall: cycles of forced zero issue slots from this group on; mask bit i marks lane i valid
00 f 0 ffff 0001 0 8000 8000 1 0000 0001 1 1234 1234
00 f 2 ffff ffff 2 f0f0 0ff0 3 0000 0000 3 a5a5 5a5a
00 f 4 ffff ffff 4 1357 2468 5 0001 000f 5 ffff 0000
00 f 6 8000 000f 6 ffff 0010 7 ffff ffff 7 0000 0000
00 a 0 1111 2222 5 00ff 0004 1 7fff ffff 6 f00d 0008
00 1 5 abcd fff0 0 0000 0000 0 0000 0000 0 0000 0000
00 0 0 dead beef 1 dead beef 2 dead beef 3 dead beef
00 8 0 0000 0000 0 0000 0000 0 0000 0000 7 5555 aaaa
00 5 3 0f00 00f0 0 9999 9999 4 aaaa 5555 0 0000 0000
14 f 0 0100 0200 1 0300 0100 2 0ff0 00ff 3 0001 0002
00 f 4 0f0f f0f0 5 8001 0001 6 8001 0001 7 1234 4321
00 f 0 fffe 0003 1 0002 0005 2 aaaa ffff 3 5555 aaaa
00 f 4 0000 ffff 5 0003 000e 6 c000 000e 0 7fff 0001
00 f 1 8000 0001 2 1248 8421 3 1248 8421 4 1248 8421
00 e 0 0000 0000 5 ffff 000f 6 ffff 000f 7 ffff 000f
00 3 0 4000 4000 1 4000 8000 0 0000 0000 0 0000 0000
00 6 0 0000 0000 2 00ff ff00 3 00ff ff00 0 0000 0000
00 c 0 0000 0000 0 0000 0000 4 00ff 0f0f 5 0f0f 0008
00 9 6 0f0f 0004 0 0000 0000 0 0000 0000 1 ffff ffff
00 f 0 0001 0001 0 0002 0002 0 0004 0004 0 0008 0008
00 0 7 0000 0000 7 0000 0000 7 0000 0000 7 0000 0000
00 2 0 0000 0000 1 0001 ffff 0 0000 0000 0 0000 0000
00 4 0 0000 0000 0 0000 0000 5 8000 0001 0 0000 0000
00 7 6 0001 0001 5 4000 0001 4 ffff 0001 0 0000 0000
00 b 3 ffff 0000 2 0000 ffff 0 0000 0000 1 8000 7fff
00 d 0 ffff ffff 0 0000 0000 2 3c3c c3c3 6 7fff 0000
00 0 0 0000 0000 0 0000 0000 0 0000 0000 0 0000 0000
00 0 0 0000 0000 0 0000 0000 0 0000 0000 0 0000 0000
10 f 0 1000 1000 1 1000 2000 2 1f1f f1f1 3 1f1f f1f1
00 f 4 1f1f f1f1 5 0101 0007 6 8080 0007 7 abcd ef01
00 f 0 fff0 0010 1 0010 fff0 2 0f0f 0f0f 3 0000 ffff
00 3 4 5555 5555 5 7777 0003 0 0000 0000 0 0000 0000
00 f 6 7777 0003 0 0abc 0def 1 0abc 0def 2 0abc 0def
00 f 3 0abc 0def 4 0abc 0def 5 0abc 000c 6 0abc 000c
00 1 7 0000 ffff 0 0000 0000 0 0000 0000 0 0000 0000
00 a 0 0000 0000 0 7fff 7fff 0 0000 0000 1 8000 8000
00 f 5 ffff 000f 5 ffff 0000 6 ffff 000f 6 ffff 0000
00 8 0 0000 0000 0 0000 0000 0 0000 0000 4 ffff 0000
00 5 1 0000 ffff 0 0000 0000 2 8421 ffff 0 0000 0000
00 f 0 0123 4567 1 89ab cdef 2 fedc ba98 3 7654 3210
00 e 0 0000 0000 4 fedc 0123 5 0001 0008 6 8000 0008
00 0 1 1111 1111 1 1111 1111 1 1111 1111 1 1111 1111
00 f 7 0001 0001 0 ffff fffe 1 fffe ffff 2 0001 0003
00 6 0 0000 0000 3 8000 0001 4 8000 0001 0 0000 0000
00 f 5 2000 0002 6 0004 0002 0 3000 d000 1 d000 3000
00 9 2 ff00 0ff0 0 0000 0000 0 0000 0000 3 ff00 0ff0
00 f 4 cafe cafe 5 cafe 0001 6 cafe 0001 7 cafe cafe
00 c 0 0000 0000 0 0000 0000 0 ffff 0002 1 0001 0002

/* test/tb_iq_core.sv */
`timescale 1ns/1ps

module tb_iq_core;

    localparam int          TIMEOUT_CYCLES = 200;
    localparam int          SETTLE_CYCLES  = 4;
    localparam logic [31:0] LFSR_SEED      = 32'd86694;
    localparam logic [31:0] LFSR_TAPS      = 32'hB4BC_D35C;

    logic                                           clk;
    logic                                           rst_n;
    logic                                           group_valid;
    logic [iq_pkg::DISPATCH_WIDTH-1:0]              lane_valid;
    uop_pkg::uop_t [iq_pkg::DISPATCH_WIDTH-1:0]     group_ops;
    iq_pkg::issue_count_t                           issue_slots;
    logic                                           group_ready;
    iq_pkg::iq_count_t                              occupancy;
    logic [iq_pkg::ISSUE_WIDTH-1:0]                 result_valid;
    uop_pkg::tag_t [iq_pkg::ISSUE_WIDTH-1:0]        result_tag;
    uop_pkg::data_t [iq_pkg::ISSUE_WIDTH-1:0]       result_data;

    // Reference model of the queue contents.
    uop_pkg::tag_t      exp_tag[$];
    uop_pkg::data_t     exp_data[$];
    uop_pkg::tag_t      next_tag;
    int                 last_ready;
    int                 last_slots;
    bit                 group_taken;

    logic [31:0]        lfsr_state;
    int                 stall_left;
    bit                 drain_mode;

    int                 value_errors;
    int                 other_errors;
    int                 results_seen;
    int                 groups_sent;
    bit                 aborted;

    iq_core u_iq_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .group_valid  (group_valid),
        .lane_valid   (lane_valid),
        .group_ops    (group_ops),
        .issue_slots  (issue_slots),
        .group_ready  (group_ready),
        .occupancy    (occupancy),
        .result_valid (result_valid),
        .result_tag   (result_tag),
        .result_data  (result_data)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end else begin
            return state >> 1;
        end
    endfunction

    function automatic int lane_count(input logic [iq_pkg::DISPATCH_WIDTH-1:0] mask);
        int n;
        n = 0;
        for (int i = 0; i < iq_pkg::DISPATCH_WIDTH; i++) begin
            if (mask[i]) begin
                n++;
            end
        end
        return n;
    endfunction

    // Arithmetic in 32 bits, then kept to the low 16.
    function automatic uop_pkg::data_t expected_result(input uop_pkg::opcode_t op,
                                                       input int a, input int b);
        int r;
        int sh;
        sh = b % 16;
        case (op)
            uop_pkg::OP_ADD: r = a + b;
            uop_pkg::OP_SUB: r = a - b;
            uop_pkg::OP_AND: r = a & b;
            uop_pkg::OP_OR:  r = a | b;
            uop_pkg::OP_XOR: r = a ^ b;
            uop_pkg::OP_SHL: r = a << sh;
            uop_pkg::OP_SHR: r = a >> sh;
            default:         r = 0;
        endcase
        return uop_pkg::data_t'(r & 32'h0000_FFFF);
    endfunction

    task automatic drive_slots();
        logic [1:0] pick;
        if (drain_mode) begin
            issue_slots = 2'd2;
        end else if (stall_left > 0) begin
            issue_slots = 2'd0;
            stall_left--;
        end else begin
            lfsr_state = lfsr_next(lfsr_state);
            pick[0] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
            pick[1] = lfsr_state[0];
            issue_slots = (pick == 2'd3) ? 2'd2 : pick;
        end
    endtask

    task automatic compare_result(input int p);
        uop_pkg::tag_t  t;
        uop_pkg::data_t d;
        if (exp_tag.size() == 0) begin
            $display("Result on port %0d with tag %h matches no accepted micro-op",
                     p, result_tag[p]);
            other_errors++;
        end else begin
            t = exp_tag.pop_front();
            d = exp_data.pop_front();
            results_seen++;
            assert (result_tag[p] == t) else begin
                $display("** Error: result_tag[%0d] = %h, expected %h", p, result_tag[p], t);
                value_errors++;
            end
            assert (result_data[p] == d) else begin
                $display("** Error: result_data[%0d] = %h, expected %h",
                         p, result_data[p], d);
                value_errors++;
            end
        end
    endtask

    // Runs at the falling edge, where every output has settled.
    task automatic check_cycle();
        int                 want_res;
        int                 size_now;
        bit                 want_ready;
        logic [1:0]         want_valid;
        uop_pkg::uop_t      op_word;
        want_res = (last_slots < last_ready) ? last_slots : last_ready;
        want_valid = (want_res == 2) ? 2'b11 : ((want_res == 1) ? 2'b01 : 2'b00);
        assert (result_valid == want_valid) else begin
            $display("** Error: result_valid = %h, expected %h", result_valid, want_valid);
            value_errors++;
        end
        for (int p = 0; p < iq_pkg::ISSUE_WIDTH; p++) begin
            if (result_valid[p]) begin
                compare_result(p);
            end
        end

        size_now = exp_tag.size();
        assert (occupancy == iq_pkg::iq_count_t'(size_now)) else begin
            $display("** Error: occupancy = %h, expected %h", occupancy, size_now);
            value_errors++;
        end
        assert (occupancy <= iq_pkg::iq_count_t'(iq_pkg::IQ_DEPTH)) else begin
            $display("** Error: occupancy = %h, limit %h", occupancy, iq_pkg::IQ_DEPTH);
            value_errors++;
        end
        want_ready = (iq_pkg::IQ_DEPTH - size_now) >= lane_count(lane_valid);
        assert (group_ready == want_ready) else begin
            $display("** Error: group_ready = %h, expected %h", group_ready, want_ready);
            value_errors++;
        end

        last_ready = (size_now < iq_pkg::ISSUE_WIDTH) ? size_now : iq_pkg::ISSUE_WIDTH;
        last_slots = int'(issue_slots);

        // Accepted lanes enter the model in lane order with running tags.
        group_taken = 1'b0;
        if (group_valid && want_ready) begin
            group_taken = 1'b1;
            for (int i = 0; i < iq_pkg::DISPATCH_WIDTH; i++) begin
                if (lane_valid[i]) begin
                    op_word = group_ops[i];
                    exp_tag.push_back(next_tag);
                    exp_data.push_back(expected_result(
                        op_word[uop_pkg::OPCODE_LSB +: uop_pkg::OPCODE_W],
                        int'(op_word[uop_pkg::A_LSB +: uop_pkg::DATA_W]),
                        int'(op_word[uop_pkg::B_LSB +: uop_pkg::DATA_W])));
                    next_tag = next_tag + 1'b1;
                end
            end
        end
    endtask

    task automatic advance_cycle();
        @(negedge clk);
        check_cycle();
        @(posedge clk);
        #1;
        drive_slots();
    endtask

    task automatic check_reset_state();
        assert (result_valid == '0) else begin
            $display("** Error: result_valid = %h, expected %h after reset", result_valid, 0);
            value_errors++;
        end
        assert (occupancy == '0) else begin
            $display("** Error: occupancy = %h, expected %h after reset", occupancy, 0);
            value_errors++;
        end
        assert (group_ready == 1'b1) else begin
            $display("** Error: group_ready = %h, expected %h after reset", group_ready, 1);
            value_errors++;
        end
    endtask

    task automatic wait_accept();
        int waited;
        waited = 0;
        group_taken = 1'b0;
        while (!group_taken && waited < TIMEOUT_CYCLES) begin
            advance_cycle();
            waited++;
        end
        if (!group_taken) begin
            $display("Timed out after %0d cycles waiting for group_ready", TIMEOUT_CYCLES);
            other_errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic drain_queue();
        int waited;
        waited = 0;
        drain_mode = 1'b1;
        issue_slots = 2'd2;
        while (exp_tag.size() > 0 && waited < TIMEOUT_CYCLES) begin
            advance_cycle();
            waited++;
        end
        if (exp_tag.size() > 0) begin
            $display("Timed out after %0d cycles with %0d micro-ops still queued",
                     TIMEOUT_CYCLES, exp_tag.size());
            other_errors++;
            aborted = 1'b1;
        end else begin
            // Stray results would show up here.
            for (int i = 0; i < SETTLE_CYCLES; i++) begin
                advance_cycle();
            end
            assert (occupancy == '0) else begin
                $display("** Error: occupancy = %h, expected %h after drain", occupancy, 0);
                value_errors++;
            end
        end
    endtask

    initial begin : main
        string  line;
        int     fd;
        int     fields;
        int     stall;
        int     mask;
        int     op[4];
        int     a[4];
        int     b[4];

        clk          = 1'b0;
        rst_n        = 1'b0;
        group_valid  = 1'b0;
        lane_valid   = '1;
        group_ops    = '0;
        issue_slots  = '0;
        next_tag     = '0;
        last_ready   = 0;
        last_slots   = 0;
        group_taken  = 1'b0;
        lfsr_state   = LFSR_SEED;
        stall_left   = 0;
        drain_mode   = 1'b0;
        value_errors = 0;
        other_errors = 0;
        results_seen = 0;
        groups_sent  = 0;
        aborted      = 1'b0;

        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        drive_slots();
        @(negedge clk);
        check_reset_state();
        @(posedge clk);
        #1;
        drive_slots();

        fd = $fopen("test/iq_core_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open test/iq_core_vectors.txt");
            other_errors++;
            aborted = 1'b1;
        end
        while (!aborted && !$feof(fd)) begin
            line = "";
            fields = $fgets(line, fd);
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                             stall, mask, op[0], a[0], b[0], op[1], a[1], b[1],
                             op[2], a[2], b[2], op[3], a[3], b[3]);
            if (fields != 14) begin
                $display("Skipping a malformed vector line: %s", line);
                other_errors++;
                continue;
            end
            group_valid = 1'b1;
            lane_valid  = mask[3:0];
            // A junk tag in every lane, the DUT has to overwrite it.
            for (int i = 0; i < iq_pkg::DISPATCH_WIDTH; i++) begin
                group_ops[i] = {uop_pkg::tag_t'(6'h2a), uop_pkg::opcode_t'(op[i]),
                                uop_pkg::data_t'(a[i]), uop_pkg::data_t'(b[i])};
            end
            if (stall > stall_left) begin
                stall_left = stall;
            end
            wait_accept();
            groups_sent++;
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        group_valid = 1'b0;
        lane_valid  = '0;
        if (!aborted) begin
            drain_queue();
        end

        $display("Summary: %0d groups, %0d results, %0d value errors, %0d other errors",
                 groups_sent, results_seen, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* logic/iq_core.sv */
`timescale 1ns/1ps

module iq_core (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                group_valid,
    input  logic [iq_pkg::DISPATCH_WIDTH-1:0]                   lane_valid,
    input  uop_pkg::uop_t [iq_pkg::DISPATCH_WIDTH-1:0]          group_ops,
    input  iq_pkg::issue_count_t                                issue_slots,
    output logic                                                group_ready,
    output iq_pkg::iq_count_t                                   occupancy,
    output logic [iq_pkg::ISSUE_WIDTH-1:0]                      result_valid,
    output uop_pkg::tag_t [iq_pkg::ISSUE_WIDTH-1:0]             result_tag,
    output uop_pkg::data_t [iq_pkg::ISSUE_WIDTH-1:0]            result_data
);

    uop_pkg::uop_t [iq_pkg::DISPATCH_WIDTH-1:0]    write_ops;
    iq_pkg::dispatch_count_t                       write_count;
    iq_pkg::iq_count_t                             free_slots;
    uop_pkg::uop_t [iq_pkg::ISSUE_WIDTH-1:0]       read_ops;
    iq_pkg::issue_count_t                          ready_count;
    iq_pkg::issue_count_t                          read_count;

    dispatch_stage u_dispatch_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .group_valid (group_valid),
        .lane_valid  (lane_valid),
        .group_ops   (group_ops),
        .free_slots  (free_slots),
        .group_ready (group_ready),
        .write_ops   (write_ops),
        .write_count (write_count)
    );

    issue_queue u_issue_queue (
        .clk         (clk),
        .rst_n       (rst_n),
        .write_ops   (write_ops),
        .write_count (write_count),
        .read_count  (read_count),
        .read_ops    (read_ops),
        .ready_count (ready_count),
        .free_slots  (free_slots),
        .occupancy   (occupancy)
    );

    issue_alu u_issue_alu (
        .clk          (clk),
        .rst_n        (rst_n),
        .read_ops     (read_ops),
        .ready_count  (ready_count),
        .issue_slots  (issue_slots),
        .read_count   (read_count),
        .result_valid (result_valid),
        .result_tag   (result_tag),
        .result_data  (result_data)
    );

endmodule

/* logic/issue_alu.sv */
`timescale 1ns/1ps

module issue_alu (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  uop_pkg::uop_t [iq_pkg::ISSUE_WIDTH-1:0]             read_ops,
    input  iq_pkg::issue_count_t                                ready_count,
    input  iq_pkg::issue_count_t                                issue_slots,
    output iq_pkg::issue_count_t                                read_count,
    output logic [iq_pkg::ISSUE_WIDTH-1:0]                      result_valid,
    output uop_pkg::tag_t [iq_pkg::ISSUE_WIDTH-1:0]             result_tag,
    output uop_pkg::data_t [iq_pkg::ISSUE_WIDTH-1:0]            result_data
);

    uop_pkg::data_t [iq_pkg::ISSUE_WIDTH-1:0]    alu_out;

    function automatic uop_pkg::data_t alu_eval(
        input uop_pkg::opcode_t op,
        input uop_pkg::data_t   a,
        input uop_pkg::data_t   b
    );
        uop_pkg::data_t r;
        case (op)
            uop_pkg::OP_ADD: r = a + b;
            uop_pkg::OP_SUB: r = a - b;
            uop_pkg::OP_AND: r = a & b;
            uop_pkg::OP_OR:  r = a | b;
            uop_pkg::OP_XOR: r = a ^ b;
            uop_pkg::OP_SHL: r = a << b[3:0];
            uop_pkg::OP_SHR: r = a >> b[3:0];
            default:         r = '0;
        endcase
        return r;
    endfunction

    // Never take more than is ready.
    assign read_count = (issue_slots < ready_count) ? issue_slots : ready_count;

    always_comb begin
        for (int i = 0; i < iq_pkg::ISSUE_WIDTH; i++) begin
            alu_out[i] = alu_eval(
                read_ops[i][uop_pkg::OPCODE_LSB +: uop_pkg::OPCODE_W],
                read_ops[i][uop_pkg::A_LSB +: uop_pkg::DATA_W],
                read_ops[i][uop_pkg::B_LSB +: uop_pkg::DATA_W]
            );
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid <= '0;
        end else begin
            // Port 0 is always the older one.
            for (int i = 0; i < iq_pkg::ISSUE_WIDTH; i++) begin
                result_valid[i] <= (iq_pkg::issue_count_t'(i) < read_count);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < iq_pkg::ISSUE_WIDTH; i++) begin
            result_tag[i]  <= read_ops[i][uop_pkg::TAG_LSB +: uop_pkg::TAG_W];
            result_data[i] <= alu_out[i];
        end
    end

endmodule

/* logic/issue_queue.sv */
`timescale 1ns/1ps

module issue_queue (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  uop_pkg::uop_t [iq_pkg::DISPATCH_WIDTH-1:0]          write_ops,
    input  iq_pkg::dispatch_count_t                             write_count,
    input  iq_pkg::issue_count_t                                read_count,
    output uop_pkg::uop_t [iq_pkg::ISSUE_WIDTH-1:0]             read_ops,
    output iq_pkg::issue_count_t                                ready_count,
    output iq_pkg::iq_count_t                                   free_slots,
    output iq_pkg::iq_count_t                                   occupancy
);

    uop_pkg::uop_t        mem [iq_pkg::IQ_DEPTH];
    iq_pkg::iq_addr_t     wr_ptr;
    iq_pkg::iq_addr_t     rd_ptr;
    iq_pkg::iq_count_t    count;

    // Up to four entries land at consecutive slots from the write pointer.
    always_ff @(posedge clk) begin
        for (int i = 0; i < iq_pkg::DISPATCH_WIDTH; i++) begin
            if (iq_pkg::dispatch_count_t'(i) < write_count) begin
                mem[wr_ptr + iq_pkg::iq_addr_t'(i)] <= write_ops[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + iq_pkg::iq_addr_t'(write_count);
            rd_ptr <= rd_ptr + iq_pkg::iq_addr_t'(read_count);
            // Simultaneous write and read net out here.
            count  <= count + iq_pkg::iq_count_t'(write_count)
                            - iq_pkg::iq_count_t'(read_count);
        end
    end

    // Oldest entries first. Empty lanes read as zero.
    always_comb begin
        for (int i = 0; i < iq_pkg::ISSUE_WIDTH; i++) begin
            if (count > iq_pkg::iq_count_t'(i)) begin
                read_ops[i] = mem[rd_ptr + iq_pkg::iq_addr_t'(i)];
            end else begin
                read_ops[i] = '0;
            end
        end
    end

    always_comb begin
        if (count >= iq_pkg::iq_count_t'(iq_pkg::ISSUE_WIDTH)) begin
            ready_count = iq_pkg::issue_count_t'(iq_pkg::ISSUE_WIDTH);
        end else begin
            ready_count = count[iq_pkg::ISSUE_CNT_W-1:0];
        end
    end

    assign free_slots = iq_pkg::iq_count_t'(iq_pkg::IQ_DEPTH) - count;
    assign occupancy  = count;

endmodule

/* logic/dispatch_stage.sv */
`timescale 1ns/1ps

module dispatch_stage (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                group_valid,
    input  logic [iq_pkg::DISPATCH_WIDTH-1:0]                   lane_valid,
    input  uop_pkg::uop_t [iq_pkg::DISPATCH_WIDTH-1:0]          group_ops,
    input  iq_pkg::iq_count_t                                   free_slots,
    output logic                                                group_ready,
    output uop_pkg::uop_t [iq_pkg::DISPATCH_WIDTH-1:0]          write_ops,
    output iq_pkg::dispatch_count_t                             write_count
);

    uop_pkg::tag_t                                     tag_cnt;
    uop_pkg::uop_t [iq_pkg::DISPATCH_WIDTH-1:0]        packed_ops;
    iq_pkg::dispatch_count_t                           lane_count;
    iq_pkg::dispatch_count_t                           space;
    logic                                              accept;

    // Compact valid lanes downward and stamp tags in order.
    always_comb begin
        iq_pkg::dispatch_count_t pos;
        pos = '0;
        packed_ops = '0;
        for (int i = 0; i < iq_pkg::DISPATCH_WIDTH; i++) begin
            if (lane_valid[i]) begin
                packed_ops[pos[1:0]] = group_ops[i];
                packed_ops[pos[1:0]][uop_pkg::TAG_LSB +: uop_pkg::TAG_W] =
                    tag_cnt + uop_pkg::tag_t'(pos);
                pos = pos + 1'b1;
            end
        end
        lane_count = pos;
    end

    // Free space clipped to one full group.
    always_comb begin
        if (free_slots >= iq_pkg::iq_count_t'(iq_pkg::DISPATCH_WIDTH)) begin
            space = iq_pkg::dispatch_count_t'(iq_pkg::DISPATCH_WIDTH);
        end else begin
            space = free_slots[iq_pkg::DISPATCH_CNT_W-1:0];
        end
    end

    assign group_ready = (space >= lane_count);
    assign accept      = group_valid && group_ready;
    assign write_ops   = packed_ops;
    assign write_count = accept ? lane_count : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tag_cnt <= '0;
        end else begin
            // Wraps at 64.
            tag_cnt <= tag_cnt + uop_pkg::tag_t'(write_count);
        end
    end

endmodule

/* logic/iq_pkg.sv */
package iq_pkg;

    // Queue geometry.
    localparam int IQ_DEPTH  = 16;
    localparam int IQ_ADDR_W = 4;
    localparam int IQ_CNT_W  = 5;

    // Lanes in and out per cycle.
    localparam int DISPATCH_WIDTH = 4;
    localparam int DISPATCH_CNT_W = 3;
    localparam int ISSUE_WIDTH    = 2;
    localparam int ISSUE_CNT_W    = 2;

    typedef logic [IQ_ADDR_W-1:0]      iq_addr_t;
    typedef logic [IQ_CNT_W-1:0]       iq_count_t;
    typedef logic [DISPATCH_CNT_W-1:0] dispatch_count_t;
    typedef logic [ISSUE_CNT_W-1:0]    issue_count_t;

endpackage

/* logic/uop_pkg.sv */
package uop_pkg;

    // Field widths of a micro-op.
    localparam int DATA_W   = 16;
    localparam int OPCODE_W = 3;
    localparam int TAG_W    = 6;
    localparam int UOP_W    = TAG_W + OPCODE_W + 2 * DATA_W;

    // Bit offsets, tag at the top and operand b at the bottom.
    localparam int B_LSB      = 0;
    localparam int A_LSB      = B_LSB + DATA_W;
    localparam int OPCODE_LSB = A_LSB + DATA_W;
    localparam int TAG_LSB    = OPCODE_LSB + OPCODE_W;

    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [OPCODE_W-1:0] opcode_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [UOP_W-1:0]    uop_t;

    // ALU operations. Code 7 yields zero.
    localparam opcode_t OP_ADD = 3'd0;
    localparam opcode_t OP_SUB = 3'd1;
    localparam opcode_t OP_AND = 3'd2;
    localparam opcode_t OP_OR  = 3'd3;
    localparam opcode_t OP_XOR = 3'd4;
    localparam opcode_t OP_SHL = 3'd5;
    localparam opcode_t OP_SHR = 3'd6;

endpackage
